//--- verilog/rvIsaPkg.sv
package rvIsaPkg;

	localparam int xlen = 32;
	localparam int regAddrWidth = 5;

	// bit positions of the instruction fields
	localparam int rdLsb = 7;
	localparam int funct3Lsb = 12;
	localparam int rs1Lsb = 15;
	localparam int rs2Lsb = 20;

	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111
	} rvOpcode;

	typedef enum logic [4:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluEq,
		aluNe,
		aluGe,
		aluGeu
	} aluOp;

	// same encoding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} memSize;

endpackage

//--- verilog/execCfgPkg.sv
package execCfgPkg;

	localparam int queueDepth = 4;
	localparam int queuePtrWidth = $clog2(queueDepth);
	localparam int queueCountWidth = $clog2(queueDepth + 1);
	localparam int memWords = 256;
	localparam int memAddrWidth = $clog2(memWords);

	typedef enum logic [1:0] {
		noWrite,
		writeAlu,
		writeLink,
		writeLoad
	} wbKind;

	typedef enum logic {
		idle,
		memWait
	} execState;

	typedef struct packed {
		rvIsaPkg::aluOp op;
		logic [rvIsaPkg::xlen-1:0] operandA;
		logic [rvIsaPkg::xlen-1:0] operandB;
		logic [rvIsaPkg::xlen-1:0] storeData;
		logic [rvIsaPkg::xlen-1:0] pc;
		logic [rvIsaPkg::xlen-1:0] imm;
		logic [rvIsaPkg::regAddrWidth-1:0] rd;
		wbKind kind;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isJalr;
		rvIsaPkg::memSize size;
		logic loadUnsigned;
	} decodedOp;

endpackage

//--- verilog/issueBus.sv
`timescale 1ns/1ps

interface issueBus;
	import execCfgPkg::*;

	decodedOp payload;
	logic valid;
	logic ready;

	modport producer (
		output payload,
		output valid,
		input ready
	);

	modport consumer (
		input payload,
		input valid,
		output ready
	);

endinterface

//--- verilog/wbBus.sv
`timescale 1ns/1ps

interface wbBus;
	import rvIsaPkg::*;

	logic cyc;
	logic stb;
	logic we;
	logic [xlen-1:0] adr;
	logic [xlen-1:0] datW;
	logic [xlen-1:0] datR;
	logic [xlen/8-1:0] sel; // one bit per byte lane
	logic ack;

	modport master (
		output cyc, stb, we, adr, datW, sel,
		input datR, ack
	);

	modport slave (
		input cyc, stb, we, adr, datW, sel,
		output datR, ack
	);

endinterface

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	input logic [rvIsaPkg::regAddrWidth-1:0] readAddrA,
	input logic [rvIsaPkg::regAddrWidth-1:0] readAddrB,
	output logic [rvIsaPkg::xlen-1:0] readDataA,
	output logic [rvIsaPkg::xlen-1:0] readDataB,
	input logic wbEnable,
	input logic [rvIsaPkg::regAddrWidth-1:0] wbRd,
	input logic [rvIsaPkg::xlen-1:0] wbData
);
	import rvIsaPkg::*;

	logic [xlen-1:0] regs [1:2**regAddrWidth-1]; // x0 has no storage

	function automatic logic [xlen-1:0] readPort(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wbEnable && wbRd == addr)
			return wbData; // writeback visible in the same cycle
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end
		else if (wbEnable && wbRd != '0)
			regs[wbRd] <= wbData;
	end

	always_comb
	begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

	// the execute stage filters x0 destinations before writeback
	assert property (@(posedge clk) disable iff (reset) wbEnable |-> wbRd != '0);

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input logic clk,
	input logic reset,
	input logic instrValid,
	output logic instrReady,
	input logic [rvIsaPkg::xlen-1:0] instr,
	input logic [rvIsaPkg::xlen-1:0] pc,
	output logic [rvIsaPkg::regAddrWidth-1:0] readAddrA,
	output logic [rvIsaPkg::regAddrWidth-1:0] readAddrB,
	input logic [rvIsaPkg::xlen-1:0] readDataA,
	input logic [rvIsaPkg::xlen-1:0] readDataB,
	input logic wbEnable,
	input logic [rvIsaPkg::regAddrWidth-1:0] wbRd,
	issueBus.producer issue
);
	import rvIsaPkg::*;
	import execCfgPkg::*;

	decodedOp decoded;
	logic [xlen-1:0] imm;
	logic [2:0] funct3;
	logic [regAddrWidth-1:0] rd;
	logic [2**regAddrWidth-1:0] pending; // scoreboard of writes in flight
	logic useA;
	logic useB;
	logic hazard;
	logic accept;

	function automatic aluOp arithOp(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? aluSub : aluAdd;
			3'd1: return aluSll;
			3'd2: return aluSlt;
			3'd3: return aluSltu;
			3'd4: return aluXor;
			3'd5: return alt ? aluSra : aluSrl;
			3'd6: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	// still pending unless the write lands in this very cycle
	function automatic logic isBlocked(input logic [regAddrWidth-1:0] r);
		return pending[r] && !(wbEnable && wbRd == r);
	endfunction

	assign readAddrA = instr[rs1Lsb +: regAddrWidth];
	assign readAddrB = instr[rs2Lsb +: regAddrWidth];
	assign rd = instr[rdLsb +: regAddrWidth];
	assign funct3 = instr[funct3Lsb +: 3];

	always_comb
	begin
		case (rvOpcode'(instr[6:0]))
			opStore: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			opBranch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			opLui, opAuipc: imm = {instr[31:12], 12'b0};
			opJal: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]}; // I format
		endcase
	end

	always_comb
	begin
		decoded = '0;
		decoded.op = aluAdd;
		decoded.operandA = readDataA;
		decoded.operandB = imm;
		decoded.storeData = readDataB;
		decoded.pc = pc;
		decoded.imm = imm;
		decoded.rd = rd;
		decoded.kind = noWrite; // unknown opcodes retire as no-op
		decoded.size = memSize'(funct3[1:0]);
		decoded.loadUnsigned = funct3[2];
		useA = 1'b0;
		useB = 1'b0;
		case (rvOpcode'(instr[6:0]))
			opReg:
			begin
				decoded.op = arithOp(funct3, instr[30]);
				decoded.operandB = readDataB;
				decoded.kind = writeAlu;
				useA = 1'b1;
				useB = 1'b1;
			end
			opImm:
			begin
				decoded.op = arithOp(funct3, funct3 == 3'd5 && instr[30]); // srai only
				decoded.kind = writeAlu;
				useA = 1'b1;
			end
			opLoad:
			begin
				decoded.isLoad = 1'b1;
				decoded.kind = writeLoad;
				useA = 1'b1;
			end
			opStore:
			begin
				decoded.isStore = 1'b1;
				useA = 1'b1;
				useB = 1'b1;
			end
			opBranch:
			begin
				decoded.isBranch = 1'b1;
				decoded.operandB = readDataB;
				useA = 1'b1;
				useB = 1'b1;
				case (funct3)
					3'd0: decoded.op = aluEq;
					3'd1: decoded.op = aluNe;
					3'd4: decoded.op = aluSlt;
					3'd5: decoded.op = aluGe;
					3'd6: decoded.op = aluSltu;
					3'd7: decoded.op = aluGeu;
					default: decoded.isBranch = 1'b0; // reserved compare
				endcase
			end
			opJal:
			begin
				decoded.operandA = pc; // target computed by the ALU
				decoded.kind = writeLink;
			end
			opJalr:
			begin
				decoded.isJalr = 1'b1;
				decoded.kind = writeLink;
				useA = 1'b1;
			end
			opLui:
			begin
				decoded.operandA = '0;
				decoded.kind = writeAlu;
			end
			opAuipc:
			begin
				decoded.operandA = pc;
				decoded.kind = writeAlu;
			end
			default: ;
		endcase
		// rd also checked so a second write to it cannot clear the bit early
		hazard = (useA && isBlocked(readAddrA)) || (useB && isBlocked(readAddrB))
			|| (decoded.kind != noWrite && isBlocked(rd));
	end

	assign instrReady = (!issue.valid || issue.ready) && !hazard;
	assign accept = instrValid && instrReady;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issue.valid <= 1'b0;
			pending <= '0;
		end
		else
		begin
			if (accept)
				issue.valid <= 1'b1;
			else if (issue.ready)
				issue.valid <= 1'b0;
			if (wbEnable)
				pending[wbRd] <= 1'b0;
			if (accept && decoded.kind != noWrite && rd != '0)
				pending[rd] <= 1'b1; // set wins over a same-cycle clear
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			issue.payload <= decoded;
	end

	assert property (@(posedge clk) disable iff (reset)
		issue.valid && !issue.ready |=> issue.valid && $stable(issue.payload));

endmodule

//--- verilog/issueQueue.sv
`timescale 1ns/1ps

module issueQueue (
	input logic clk,
	input logic reset,
	issueBus.consumer inBus,
	issueBus.producer outBus
);
	import execCfgPkg::*;

	decodedOp entries [queueDepth];
	logic [queuePtrWidth-1:0] wrPtr;
	logic [queuePtrWidth-1:0] rdPtr;
	logic [queueCountWidth-1:0] count;
	logic full;
	logic push;
	logic pop;

	function automatic logic [queuePtrWidth-1:0] advance(input logic [queuePtrWidth-1:0] ptr);
		return (ptr == queuePtrWidth'(queueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == queueCountWidth'(queueDepth));
	assign push = inBus.valid && !full;
	assign pop = outBus.valid && outBus.ready;
	assign inBus.ready = !full;
	assign outBus.valid = (count != '0);
	assign outBus.payload = entries[rdPtr]; // head straight from storage

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= advance(wrPtr);
			if (pop)
				rdPtr <= advance(rdPtr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wrPtr] <= inBus.payload;
	end

	// nothing is written while full and no slot is freed
	assert property (@(posedge clk) disable iff (reset)
		full && !pop |=> full && $stable(wrPtr));

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic reset,
	issueBus.consumer issue,
	wbBus.master wb,
	output logic wbEnable,
	output logic [rvIsaPkg::regAddrWidth-1:0] wbRd,
	output logic [rvIsaPkg::xlen-1:0] wbData,
	output logic retireValid,
	output logic [rvIsaPkg::regAddrWidth-1:0] retireRd,
	output logic [rvIsaPkg::xlen-1:0] retireData,
	output logic branchTaken,
	output logic [rvIsaPkg::xlen-1:0] nextPc
);
	import rvIsaPkg::*;
	import execCfgPkg::*;

	execState state;
	decodedOp head;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] linkPc;
	logic [xlen-1:0] targetPc;
	logic taken;
	logic isMem;
	logic take;
	logic [1:0] lane;
	memSize loadSize;
	logic loadZeroExt;
	logic memLoad;
	logic [xlen-1:0] laneData;
	logic [xlen-1:0] loadValue;

	assign head = issue.payload;
	assign issue.ready = (state == idle);
	assign take = (state == idle) && issue.valid;

	always_comb
	begin
		case (head.op)
			aluSub: aluResult = head.operandA - head.operandB;
			aluSll: aluResult = head.operandA << head.operandB[4:0];
			aluSlt: aluResult = xlen'($signed(head.operandA) < $signed(head.operandB));
			aluSltu: aluResult = xlen'(head.operandA < head.operandB);
			aluXor: aluResult = head.operandA ^ head.operandB;
			aluSrl: aluResult = head.operandA >> head.operandB[4:0];
			aluSra: aluResult = $signed(head.operandA) >>> head.operandB[4:0];
			aluOr: aluResult = head.operandA | head.operandB;
			aluAnd: aluResult = head.operandA & head.operandB;
			aluEq: aluResult = xlen'(head.operandA == head.operandB);
			aluNe: aluResult = xlen'(head.operandA != head.operandB);
			aluGe: aluResult = xlen'($signed(head.operandA) >= $signed(head.operandB));
			aluGeu: aluResult = xlen'(head.operandA >= head.operandB);
			default: aluResult = head.operandA + head.operandB;
		endcase
	end

	assign taken = head.isBranch && aluResult[0];
	assign linkPc = head.pc + 32'd4;
	assign isMem = head.isLoad || head.isStore;
	assign lane = aluResult[1:0];

	always_comb
	begin
		if (head.isJalr)
			targetPc = {aluResult[xlen-1:1], 1'b0};
		else if (head.kind == writeLink)
			targetPc = aluResult; // jal target pc plus imm
		else if (taken)
			targetPc = head.pc + head.imm;
		else
			targetPc = linkPc;
	end

	// load lane picked by the address still held on the bus
	assign laneData = wb.datR >> {wb.adr[1:0], 3'b000};

	always_comb
	begin
		case (loadSize)
			sizeByte: loadValue = loadZeroExt ? {24'b0, laneData[7:0]}
				: {{24{laneData[7]}}, laneData[7:0]};
			sizeHalf: loadValue = loadZeroExt ? {16'b0, laneData[15:0]}
				: {{16{laneData[15]}}, laneData[15:0]};
			default: loadValue = laneData;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			wb.cyc <= 1'b0;
			wb.stb <= 1'b0;
			retireValid <= 1'b0;
			wbEnable <= 1'b0;
		end
		else
		begin
			retireValid <= 1'b0;
			wbEnable <= 1'b0;
			if (take && isMem)
			begin
				wb.cyc <= 1'b1;
				wb.stb <= 1'b1;
				state <= memWait;
			end
			else if (take)
			begin
				retireValid <= 1'b1;
				wbEnable <= head.kind != noWrite && head.rd != '0;
			end
			else if (state == memWait && wb.ack)
			begin
				wb.cyc <= 1'b0;
				wb.stb <= 1'b0;
				retireValid <= 1'b1;
				wbEnable <= memLoad && wbRd != '0;
				state <= idle;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			branchTaken <= taken;
			nextPc <= targetPc;
			wbRd <= head.rd;
			wbData <= (head.kind == writeLink) ? linkPc : aluResult;
			wb.we <= head.isStore;
			wb.adr <= aluResult;
			loadSize <= head.size;
			loadZeroExt <= head.loadUnsigned;
			memLoad <= head.isLoad;
			case (head.size)
				sizeByte:
				begin
					wb.sel <= 4'b0001 << lane;
					wb.datW <= {4{head.storeData[7:0]}};
				end
				sizeHalf:
				begin
					wb.sel <= 4'b0011 << {lane[1], 1'b0};
					wb.datW <= {2{head.storeData[15:0]}};
				end
				default:
				begin
					wb.sel <= 4'b1111;
					wb.datW <= head.storeData;
				end
			endcase
		end
		else if (state == memWait && wb.ack)
			wbData <= loadValue;
	end

	// retire reports only what was really written
	assign retireRd = wbEnable ? wbRd : '0;
	assign retireData = wbEnable ? wbData : '0;

	assert property (@(posedge clk) disable iff (reset) wb.stb |-> wb.cyc);

endmodule

//--- verilog/dataMem.sv
`timescale 1ns/1ps

module dataMem (
	input logic clk,
	input logic reset,
	wbBus.slave bus
);
	import rvIsaPkg::*;
	import execCfgPkg::*;

	logic [xlen-1:0] mem [memWords];
	logic [memAddrWidth-1:0] wordAddr;
	logic request;

	assign wordAddr = bus.adr[memAddrWidth+1:2];
	assign request = bus.cyc && bus.stb && !bus.ack; // one ack per request

	always_ff @(posedge clk)
	begin
		if (reset)
			bus.ack <= 1'b0;
		else
			bus.ack <= request;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < memWords; i++)
				mem[i] <= '0;
		end
		else if (request && bus.we)
		begin
			for (int b = 0; b < xlen/8; b++)
				if (bus.sel[b])
					mem[wordAddr][b*8 +: 8] <= bus.datW[b*8 +: 8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (request)
			bus.datR <= mem[wordAddr]; // valid together with ack
	end

endmodule

//--- verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit (
	input logic clk,
	input logic reset,
	input logic instrValid,
	output logic instrReady,
	input logic [rvIsaPkg::xlen-1:0] instr,
	input logic [rvIsaPkg::xlen-1:0] pc,
	output logic retireValid,
	output logic [rvIsaPkg::regAddrWidth-1:0] retireRd,
	output logic [rvIsaPkg::xlen-1:0] retireData,
	output logic branchTaken,
	output logic [rvIsaPkg::xlen-1:0] nextPc
);
	import rvIsaPkg::*;

	logic [regAddrWidth-1:0] readAddrA;
	logic [regAddrWidth-1:0] readAddrB;
	logic [xlen-1:0] readDataA;
	logic [xlen-1:0] readDataB;
	logic wbEnable;
	logic [regAddrWidth-1:0] wbRd;
	logic [xlen-1:0] wbData;

	issueBus decodeBus (); // decoder to queue
	issueBus headBus (); // queue head to execute
	wbBus dataBus ();

	regFile u_regFile (.clk, .reset, .readAddrA, .readAddrB, .readDataA, .readDataB,
		.wbEnable, .wbRd, .wbData);

	instrDecoder u_instrDecoder (.clk, .reset, .instrValid, .instrReady, .instr, .pc,
		.readAddrA, .readAddrB, .readDataA, .readDataB, .wbEnable, .wbRd,
		.issue(decodeBus.producer));

	issueQueue u_issueQueue (.clk, .reset, .inBus(decodeBus.consumer),
		.outBus(headBus.producer));

	executeStage u_executeStage (.clk, .reset, .issue(headBus.consumer),
		.wb(dataBus.master), .wbEnable, .wbRd, .wbData, .retireValid, .retireRd,
		.retireData, .branchTaken, .nextPc);

	dataMem u_dataMem (.clk, .reset, .bus(dataBus.slave));

endmodule

//--- tests/execChecker.sv
`timescale 1ns/1ps

module execChecker (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic instrReady,
	input logic [rvIsaPkg::xlen-1:0] instr,
	input logic [rvIsaPkg::xlen-1:0] pc,
	input logic retireValid,
	input logic [rvIsaPkg::regAddrWidth-1:0] retireRd,
	input logic [rvIsaPkg::xlen-1:0] retireData,
	input logic branchTaken,
	input logic [rvIsaPkg::xlen-1:0] nextPc,
	output logic [rvIsaPkg::xlen-1:0] expectNextPc,
	output int errors,
	output int retired,
	output int outstanding
);
	import rvIsaPkg::*;
	import execCfgPkg::*;

	typedef struct packed {
		logic [regAddrWidth-1:0] rd;
		logic [xlen-1:0] data;
		logic taken;
		logic [xlen-1:0] nextPc;
	} refResult;

	logic [xlen-1:0] regs [32]; // architectural state in program order
	logic [xlen-1:0] mem [memWords];
	refResult expected [$];

	function automatic logic [xlen-1:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(input logic [2:0] f3, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [xlen-1:0] loadRef(input logic [2:0] f3, input logic [xlen-1:0] addr);
		logic [xlen-1:0] word;
		word = mem[addr[memAddrWidth+1:2]] >> (8 * addr[1:0]); // addressed byte to bit 0
		case (f3)
			3'd0: return {{24{word[7]}}, word[7:0]};
			3'd1: return {{16{word[15]}}, word[15:0]};
			3'd4: return {24'b0, word[7:0]};
			3'd5: return {16'b0, word[15:0]};
			default: return word;
		endcase
	endfunction

	// expected retire report of one instruction against the current state
	function automatic refResult refExec(input logic [xlen-1:0] ins, input logic [xlen-1:0] at);
		refResult r;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] immI;
		logic [xlen-1:0] res;
		logic [2:0] f3;
		logic writes;
		a = regs[ins[19:15]];
		b = regs[ins[24:20]];
		f3 = ins[14:12];
		immI = {{20{ins[31]}}, ins[31:20]};
		res = '0;
		writes = 1'b1;
		r.taken = 1'b0;
		r.nextPc = at + 32'd4;
		case (ins[6:0])
			opReg: res = aluRef(f3, ins[30], a, b);
			opImm: res = aluRef(f3, f3 == 3'd5 && ins[30], a, immI);
			opLoad: res = loadRef(f3, a + immI);
			opLui: res = {ins[31:12], 12'b0};
			opAuipc: res = at + {ins[31:12], 12'b0};
			opJal:
			begin
				res = at + 32'd4;
				r.nextPc = at + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			opJalr:
			begin
				res = at + 32'd4;
				r.nextPc = (a + immI) & ~32'd1;
			end
			opBranch:
			begin
				writes = 1'b0;
				r.taken = branchRef(f3, a, b);
				if (r.taken)
					r.nextPc = at + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			default: writes = 1'b0; // stores and no-ops
		endcase
		r.rd = (writes && ins[11:7] != 5'd0) ? ins[11:7] : 5'd0;
		r.data = (r.rd != 5'd0) ? res : '0;
		return r;
	endfunction

	task automatic applyStore(input logic [xlen-1:0] ins);
		logic [xlen-1:0] addr;
		addr = regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
		for (int i = 0; i < 4; i++)
			if (i >= addr[1:0] && i < addr[1:0] + (1 << ins[13:12])) // bytes covered by size
				mem[addr[memAddrWidth+1:2]][i*8 +: 8] = regs[ins[24:20]][(i - addr[1:0])*8 +: 8];
	endtask

	task automatic checkField(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] want);
		if (got !== want)
		begin
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic compareRetire();
		refResult e;
		if (expected.size() == 0)
		begin
			$display("unexpected retire at %0t with no instruction outstanding", $time);
			errors++;
			return;
		end
		e = expected.pop_front(); // oldest accepted instruction
		retired++;
		checkField("retireRd", 32'(retireRd), 32'(e.rd));
		checkField("retireData", retireData, e.data);
		checkField("branchTaken", 32'(branchTaken), 32'(e.taken));
		checkField("nextPc", nextPc, e.nextPc);
	endtask

	// sampled mid-cycle where DUT ports are settled
	always @(negedge clk)
	begin
		refResult r;
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] = '0;
			for (int i = 0; i < memWords; i++)
				mem[i] = '0;
			expected.delete();
			errors = 0;
			retired = 0;
			expectNextPc = '0;
		end
		else
		begin
			if (retireValid)
				compareRetire();
			if (instrValid && instrReady) // accepted at the coming edge
			begin
				r = refExec(instr, pc);
				expected.push_back(r);
				expectNextPc = r.nextPc;
				if (instr[6:0] == opStore)
					applyStore(instr);
				if (r.rd != 5'd0)
					regs[r.rd] = r.data;
			end
		end
		outstanding = expected.size();
	end

endmodule

//--- tests/tbExecUnit.sv
`timescale 1ns/1ps

module tbExecUnit;
	import rvIsaPkg::*;

	localparam int aluCount = 56;
	localparam int jumpCount = 24;
	localparam int branchCount = 32;
	localparam int memCount = 72;
	localparam int hazardCount = 56;
	localparam int cycleLimit =
		40 * (aluCount + jumpCount + branchCount + memCount + hazardCount) + 200;

	logic clk;
	logic reset;
	logic instrValid;
	logic instrReady;
	logic [xlen-1:0] instr;
	logic [xlen-1:0] pc;
	logic retireValid;
	logic [regAddrWidth-1:0] retireRd;
	logic [xlen-1:0] retireData;
	logic branchTaken;
	logic [xlen-1:0] nextPc;
	logic [xlen-1:0] expectNextPc;
	logic [xlen-1:0] curPc;
	int errors;
	int retired;
	int outstanding;
	int cycles = 0;
	int sent = 0;
	int testsRun = 0;
	int errorsBefore = 0;
	integer seed;

	execUnit u_execUnit (.clk, .reset, .instrValid, .instrReady, .instr, .pc, .retireValid,
		.retireRd, .retireData, .branchTaken, .nextPc);

	execChecker u_checker (.clk, .reset, .instrValid, .instrReady, .instr, .pc, .retireValid,
		.retireRd, .retireData, .branchTaken, .nextPc, .expectNextPc, .errors, .retired,
		.outstanding);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout after %0d cycles with %0d instructions still outstanding",
				cycleLimit, outstanding);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// register or immediate ALU op on x1 up to x(span)
	function automatic logic [31:0] randomAlu(input int span);
		logic [2:0] f3;
		logic alt;
		logic [4:0] rd;
		logic [4:0] rs1;
		f3 = 3'(pick(8));
		alt = (f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1;
		rd = 5'(1 + pick(span));
		rs1 = 5'(1 + pick(span));
		if (pick(2) == 0)
			return encR({1'b0, alt, 5'b0}, 5'(1 + pick(span)), rs1, f3, rd);
		if (f3 == 3'd1 || f3 == 3'd5)
			return encI({1'b0, alt, 5'b0, 5'(pick(32))}, rs1, f3, rd, opImm); // shamt form
		return encI(12'(pick(4096)), rs1, f3, rd, opImm);
	endfunction

	// holds the instruction until the edge that accepts it
	task automatic send(input logic [31:0] word);
		logic accepted;
		instr = word;
		pc = curPc;
		instrValid = 1'b1;
		do
		begin
			@(negedge clk);
			accepted = instrReady;
			@(posedge clk);
			#1;
		end
		while (!accepted);
		curPc = expectNextPc; // reference nextPc of the accepted one
		sent++;
	endtask

	task automatic finishTest(input string name);
		instrValid = 1'b0;
		while (outstanding != 0)
			@(posedge clk);
		#1;
		testsRun++;
		$display("test %0d %s finished: %0d sent, %0d retired, %0d errors", testsRun, name,
			sent, retired, errors - errorsBefore);
		errorsBefore = errors;
	endtask

	task automatic aluTest();
		for (int r = 1; r <= 8; r++)
		begin
			send(encU(20'(pick(1 << 20)) | (r == 8 ? 20'h80000 : 20'h0), 5'(r), opLui));
			send(encI(12'(pick(4096)), 5'(r), 3'd0, 5'(r), opImm));
		end
		send(encI({7'b0100000, 5'(pick(32))}, 5'd8, 3'd5, 5'd9, opImm)); // srai of negative x8
		send(encR(7'b0100000, 5'd1, 5'd8, 3'd5, 5'd9));
		repeat (38) send(randomAlu(9));
	endtask

	task automatic jumpTest();
		logic [4:0] rd;
		repeat (6)
		begin
			rd = 5'(1 + pick(9));
			send(encU(20'(pick(1 << 20)), rd, opLui));
			send(encU(20'(pick(1 << 20)), 5'(1 + pick(9)), opAuipc));
			send(encJ({20'(pick(1 << 20)), 1'b0}, 5'(1 + pick(9))));
			send(encI({11'(pick(2048)), 1'b1}, rd, 3'd0, 5'(1 + pick(9)), opJalr)); // odd target
		end
	endtask

	task automatic branchTest();
		int pairA [4] = '{5, -3, 7, 2};
		int pairB [4] = '{5, 7, -3, 9};
		logic [2:0] compares [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int p = 0; p < 4; p++)
		begin
			send(encI(12'(pairA[p]), 5'd0, 3'd0, 5'd11, opImm));
			send(encI(12'(pairB[p]), 5'd0, 3'd0, 5'd12, opImm));
			for (int c = 0; c < 6; c++)
				send(encB({12'(pick(4096)), 1'b0}, 5'd12, 5'd11, compares[c]));
		end
	endtask

	task automatic memoryTest();
		int kind;
		repeat (8)
		begin
			send(encI(12'(pick(240) * 4), 5'd0, 3'd0, 5'd10, opImm)); // word aligned base
			send(encU(20'(pick(1 << 20)), 5'd13, opLui));
			send(encI(12'(pick(4096)), 5'd13, 3'd0, 5'd13, opImm));
			kind = pick(3);
			case (kind)
				0: send(encS(12'(pick(4)), 5'd13, 5'd10, 3'd0));
				1: send(encS(12'(pick(2) * 2), 5'd13, 5'd10, 3'd1));
				default: send(encS(12'd0, 5'd13, 5'd10, 3'd2));
			endcase
			send(encI(12'd0, 5'd10, 3'd2, 5'd14, opLoad));
			send(encI(12'(pick(2) * 2), 5'd10, 3'd1, 5'd15, opLoad));
			send(encI(12'(pick(2) * 2), 5'd10, 3'd5, 5'd16, opLoad));
			send(encI(12'(pick(4)), 5'd10, 3'd0, 5'd17, opLoad));
			send(encI(12'(pick(4)), 5'd10, 3'd4, 5'd18, opLoad));
		end
	endtask

	task automatic hazardTest();
		repeat (4)
		begin
			send(encI(12'(pick(240) * 4), 5'd0, 3'd0, 5'd10, opImm));
			for (int k = 0; k < 4; k++)
				send(encI(12'(4 * k), 5'd10, 3'd2, 5'(24 + k), opLoad));
			repeat (4) send(randomAlu(9)); // independent burst behind the loads
			send(encI(12'd1, 5'd24, 3'd0, 5'd20, opImm));
			send(encI(12'd1, 5'd20, 3'd0, 5'd20, opImm));
			send(encR(7'b0, 5'd27, 5'd20, 3'd0, 5'd21));
			send(encR(7'b0, 5'd21, 5'd20, 3'd0, 5'd0)); // write to x0 dropped
			send(encR(7'b0, 5'd0, 5'd0, 3'd0, 5'd22));
		end
	endtask

	initial
	begin
		seed = 54;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		curPc = 32'h100;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		aluTest();
		finishTest("register and immediate ALU");
		jumpTest();
		finishTest("upper immediates and jumps");
		branchTest();
		finishTest("branches");
		memoryTest();
		finishTest("loads and stores");
		hazardTest();
		finishTest("hazards and back-pressure");
		if (retired != sent)
			$display("retired count %0d does not match accepted count %0d", retired, sent);
		$display("%0d tests, %0d instructions accepted, %0d retired, %0d errors", testsRun,
			sent, retired, errors);
		if (errors == 0 && retired == sent)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb.f
verilog/rvIsaPkg.sv
verilog/execCfgPkg.sv
verilog/issueBus.sv
verilog/wbBus.sv
verilog/regFile.sv
verilog/instrDecoder.sv
verilog/issueQueue.sv
verilog/executeStage.sv
verilog/dataMem.sv
verilog/execUnit.sv
tests/execChecker.sv
tests/tbExecUnit.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - verilog/rvIsaPkg.sv
  - verilog/execCfgPkg.sv
  - verilog/issueBus.sv
  - verilog/wbBus.sv
  - verilog/regFile.sv
  - verilog/instrDecoder.sv
  - verilog/issueQueue.sv
  - verilog/executeStage.sv
  - verilog/dataMem.sv
  - verilog/execUnit.sv
  - target: test
    files:
      - tests/execChecker.sv
      - tests/tbExecUnit.sv
